// ==== include/rv_pipe_cfg.svh ====
`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

`define RV_XLEN 64

// alu operation codes
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_AND  4'd2
`define ALU_OR   4'd3
`define ALU_XOR  4'd4
`define ALU_SLL  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_SLT  4'd8
`define ALU_SLTU 4'd9

`define OPA_REG  2'd0
`define OPA_PC   2'd1
`define OPA_ZERO 2'd2
`define OPB_REG  2'd0
`define OPB_IMM  2'd1

`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_BRANCH 7'b1100011

`endif

// ==== logic/alu.sv ====
`default_nettype none

`include "rv_pipe_cfg.svh"

module alu (
    input  rv_pipe_pkg::alu_op_t alu_op,
    input  rv_pipe_pkg::xlen_t   alu_a,
    input  rv_pipe_pkg::xlen_t   alu_b,
    output rv_pipe_pkg::xlen_t   alu_result
);
    logic [5:0] shamt;

    assign shamt = alu_b[5:0]; // rv64 shift amount

    always_comb begin
        case (alu_op)
            `ALU_ADD:  alu_result = alu_a + alu_b;
            `ALU_SUB:  alu_result = alu_a - alu_b;
            `ALU_AND:  alu_result = alu_a & alu_b;
            `ALU_OR:   alu_result = alu_a | alu_b;
            `ALU_XOR:  alu_result = alu_a ^ alu_b;
            `ALU_SLL:  alu_result = alu_a << shamt;
            `ALU_SRL:  alu_result = alu_a >> shamt;
            `ALU_SRA:  alu_result = $signed(alu_a) >>> shamt;
            `ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            `ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            default:   alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`default_nettype none

module branch_unit (
    input  rv_pipe_pkg::br_cond_t br_cond,
    input  logic                  is_branch,
    input  rv_pipe_pkg::xlen_t    src1,
    input  rv_pipe_pkg::xlen_t    src2,
    input  rv_pipe_pkg::xlen_t    imm,
    input  rv_pipe_pkg::xlen_t    pc,
    output logic                  br_taken,
    output rv_pipe_pkg::xlen_t    br_target
);
    logic cond;

    always_comb begin
        case (br_cond)
            3'b000:  cond = src1 == src2;                   // beq
            3'b001:  cond = src1 != src2;                   // bne
            3'b100:  cond = $signed(src1) < $signed(src2);  // blt
            3'b101:  cond = $signed(src1) >= $signed(src2); // bge
            3'b110:  cond = src1 < src2;                    // bltu
            3'b111:  cond = src1 >= src2;                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign br_taken  = is_branch && cond;
    assign br_target = pc + imm;

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

`include "rv_pipe_cfg.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  rv_pipe_pkg::inst_t     in_inst,
    input  rv_pipe_pkg::xlen_t     in_pc,
    output logic                   in_allowin,
    input  logic                   es_allowin,
    input  rv_pipe_pkg::reg_idx_t  es_busy_rd,
    input  logic                   es_busy_wen,
    input  rv_pipe_pkg::reg_idx_t  rs_busy_rd,
    input  logic                   rs_busy_wen,
    output rv_pipe_pkg::reg_idx_t  rf_raddr1,
    output rv_pipe_pkg::reg_idx_t  rf_raddr2,
    input  rv_pipe_pkg::xlen_t     rf_rdata1,
    input  rv_pipe_pkg::xlen_t     rf_rdata2,
    output logic                   ds_to_es_valid,
    output rv_pipe_pkg::xlen_t     ds_pc,
    output rv_pipe_pkg::xlen_t     ds_src1,
    output rv_pipe_pkg::xlen_t     ds_src2,
    output rv_pipe_pkg::xlen_t     ds_imm,
    output rv_pipe_pkg::alu_op_t   ds_alu_op,
    output rv_pipe_pkg::opa_sel_t  ds_opa_sel,
    output rv_pipe_pkg::opb_sel_t  ds_opb_sel,
    output rv_pipe_pkg::reg_idx_t  ds_rd,
    output logic                   ds_reg_wen,
    output logic                   ds_is_branch,
    output rv_pipe_pkg::br_cond_t  ds_br_cond
);
    logic                  ds_valid;
    logic                  ds_ready_go;
    rv_pipe_pkg::inst_t    ds_inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic                  is_op, is_op_imm, is_lui, is_auipc;
    logic                  use_rs1, use_rs2;
    logic                  hit1, hit2;

    assign in_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (in_allowin) begin
            ds_valid <= in_valid;
        end
        if (in_valid && in_allowin) begin
            ds_inst <= in_inst;
            ds_pc   <= in_pc;
        end
    end

    assign opcode     = ds_inst[6:0];
    assign funct3     = ds_inst[14:12];
    assign rf_raddr1  = ds_inst[19:15];
    assign rf_raddr2  = ds_inst[24:20];
    assign ds_rd      = ds_inst[11:7];
    assign ds_br_cond = funct3;

    // funct7 0100000 only selects sub and sra
    assign is_op = (opcode == `OPC_OP) && ((ds_inst[31:25] == 7'b0000000) ||
                   ((ds_inst[31:25] == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));
    // shift immediates must carry a legal upper field
    assign is_op_imm = (opcode == `OPC_OP_IMM) && ((funct3[1:0] != 2'b01) ||
                       (ds_inst[31:26] == 6'b000000) || ((ds_inst[31:26] == 6'b010000) && funct3[2]));
    assign is_lui       = opcode == `OPC_LUI;
    assign is_auipc     = opcode == `OPC_AUIPC;
    assign ds_is_branch = (opcode == `OPC_BRANCH) && (funct3[2:1] != 2'b01);

    always_comb begin
        case (funct3)
            3'b000:  ds_alu_op = (is_op && ds_inst[30]) ? `ALU_SUB : `ALU_ADD;
            3'b001:  ds_alu_op = `ALU_SLL;
            3'b010:  ds_alu_op = `ALU_SLT;
            3'b011:  ds_alu_op = `ALU_SLTU;
            3'b100:  ds_alu_op = `ALU_XOR;
            3'b101:  ds_alu_op = ds_inst[30] ? `ALU_SRA : `ALU_SRL;
            3'b110:  ds_alu_op = `ALU_OR;
            default: ds_alu_op = `ALU_AND;
        endcase
        if (is_lui || is_auipc) begin
            ds_alu_op = `ALU_ADD; // upper immediates go through the adder
        end
    end

    always_comb begin
        if (is_op_imm) begin
            ds_imm = {{(`RV_XLEN-12){ds_inst[31]}}, ds_inst[31:20]};
        end else if (is_lui || is_auipc) begin
            ds_imm = {{(`RV_XLEN-32){ds_inst[31]}}, ds_inst[31:12], 12'b0};
        end else begin
            ds_imm = {{(`RV_XLEN-12){ds_inst[31]}}, ds_inst[7], ds_inst[30:25],
                      ds_inst[11:8], 1'b0}; // B-type
        end
    end

    assign ds_opa_sel = is_lui ? `OPA_ZERO : (is_auipc ? `OPA_PC : `OPA_REG);
    assign ds_opb_sel = is_op ? `OPB_REG : `OPB_IMM;
    assign ds_reg_wen = (is_op || is_op_imm || is_lui || is_auipc) && (ds_rd != 5'd0);
    assign ds_src1    = rf_rdata1;
    assign ds_src2    = rf_rdata2;

    // interlock: wait until the producer has retired
    assign use_rs1 = is_op || is_op_imm || ds_is_branch;
    assign use_rs2 = is_op || ds_is_branch;
    assign hit1 = use_rs1 && ((es_busy_wen && es_busy_rd == rf_raddr1) ||
                              (rs_busy_wen && rs_busy_rd == rf_raddr1));
    assign hit2 = use_rs2 && ((es_busy_wen && es_busy_rd == rf_raddr2) ||
                              (rs_busy_wen && rs_busy_rd == rf_raddr2));
    assign ds_ready_go = !(hit1 || hit2);

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

`include "rv_pipe_cfg.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ds_to_es_valid,
    input  rv_pipe_pkg::xlen_t     ds_pc,
    input  rv_pipe_pkg::xlen_t     ds_src1,
    input  rv_pipe_pkg::xlen_t     ds_src2,
    input  rv_pipe_pkg::xlen_t     ds_imm,
    input  rv_pipe_pkg::alu_op_t   ds_alu_op,
    input  rv_pipe_pkg::opa_sel_t  ds_opa_sel,
    input  rv_pipe_pkg::opb_sel_t  ds_opb_sel,
    input  rv_pipe_pkg::reg_idx_t  ds_rd,
    input  logic                   ds_reg_wen,
    input  logic                   ds_is_branch,
    input  rv_pipe_pkg::br_cond_t  ds_br_cond,
    output logic                   es_allowin,
    output rv_pipe_pkg::reg_idx_t  es_busy_rd,
    output logic                   es_busy_wen,
    input  logic                   rs_allowin,
    output logic                   es_to_rs_valid,
    output rv_pipe_pkg::xlen_t     es_pc,
    output rv_pipe_pkg::reg_idx_t  es_rd,
    output logic                   es_reg_wen,
    output rv_pipe_pkg::xlen_t     es_result,
    output logic                   es_br_taken,
    output rv_pipe_pkg::xlen_t     es_br_target
);
    logic                  es_valid;
    rv_pipe_pkg::xlen_t    es_src1, es_src2, es_imm;
    rv_pipe_pkg::alu_op_t  es_alu_op;
    rv_pipe_pkg::opa_sel_t es_opa_sel;
    rv_pipe_pkg::opb_sel_t es_opb_sel;
    logic                  es_is_branch;
    rv_pipe_pkg::br_cond_t es_br_cond;
    rv_pipe_pkg::xlen_t    alu_a, alu_b;

    assign es_allowin     = !es_valid || rs_allowin;
    assign es_to_rs_valid = es_valid; // single-cycle alu
    assign es_busy_rd     = es_rd;
    assign es_busy_wen    = es_valid && es_reg_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            es_pc        <= ds_pc;
            es_src1      <= ds_src1;
            es_src2      <= ds_src2;
            es_imm       <= ds_imm;
            es_alu_op    <= ds_alu_op;
            es_opa_sel   <= ds_opa_sel;
            es_opb_sel   <= ds_opb_sel;
            es_rd        <= ds_rd;
            es_reg_wen   <= ds_reg_wen;
            es_is_branch <= ds_is_branch;
            es_br_cond   <= ds_br_cond;
        end
    end

    always_comb begin
        case (es_opa_sel)
            `OPA_REG: alu_a = es_src1;
            `OPA_PC:  alu_a = es_pc;
            default:  alu_a = '0; // lui
        endcase
        alu_b = (es_opb_sel == `OPB_REG) ? es_src2 : es_imm;
    end

    alu u_alu (
        .alu_op     (es_alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (es_result)
    );

    branch_unit u_branch_unit (
        .br_cond   (es_br_cond),
        .is_branch (es_is_branch),
        .src1      (es_src1),
        .src2      (es_src2),
        .imm       (es_imm),
        .pc        (es_pc),
        .br_taken  (es_br_taken),
        .br_target (es_br_target)
    );

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_pipe_pkg::reg_idx_t raddr1,
    input  rv_pipe_pkg::reg_idx_t raddr2,
    output rv_pipe_pkg::xlen_t    rdata1,
    output rv_pipe_pkg::xlen_t    rdata2,
    input  logic                  we,
    input  rv_pipe_pkg::reg_idx_t waddr,
    input  rv_pipe_pkg::xlen_t    wdata
);
    // entry 0 is cleared on reset and never written
    rv_pipe_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/result_stage.sv ====
`default_nettype none

module result_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  es_to_rs_valid,
    input  rv_pipe_pkg::xlen_t    es_pc,
    input  rv_pipe_pkg::reg_idx_t es_rd,
    input  logic                  es_reg_wen,
    input  rv_pipe_pkg::xlen_t    es_result,
    input  logic                  es_br_taken,
    input  rv_pipe_pkg::xlen_t    es_br_target,
    output logic                  rs_allowin,
    output logic                  retire_valid,
    output rv_pipe_pkg::xlen_t    retire_pc,
    output rv_pipe_pkg::reg_idx_t retire_rd,
    output logic                  retire_wen,
    output rv_pipe_pkg::xlen_t    retire_value,
    output logic                  retire_br_taken,
    output rv_pipe_pkg::xlen_t    retire_br_target,
    input  logic                  retire_ready,
    output logic                  rf_we,
    output rv_pipe_pkg::reg_idx_t rf_waddr,
    output rv_pipe_pkg::xlen_t    rf_wdata
);
    logic rs_valid;
    logic rs_reg_wen;

    assign rs_allowin   = !rs_valid || retire_ready;
    assign retire_valid = rs_valid;
    assign retire_wen   = rs_valid && rs_reg_wen; // also the interlock's pending flag

    always_ff @(posedge clk) begin
        if (rst) begin
            rs_valid <= 1'b0;
        end else if (rs_allowin) begin
            rs_valid <= es_to_rs_valid;
        end
        if (es_to_rs_valid && rs_allowin) begin
            retire_pc        <= es_pc;
            retire_rd        <= es_rd;
            rs_reg_wen       <= es_reg_wen;
            retire_value     <= es_result;
            retire_br_taken  <= es_br_taken;
            retire_br_target <= es_br_target;
        end
    end

    // write back on the retire handshake
    assign rf_we    = retire_wen && retire_ready;
    assign rf_waddr = retire_rd;
    assign rf_wdata = retire_value;

endmodule

`default_nettype wire

// ==== logic/rv_pipe_pkg.sv ====
`default_nettype none

`include "rv_pipe_cfg.svh"

package rv_pipe_pkg;

    // data value or pc
    typedef logic [`RV_XLEN-1:0] xlen_t;

    typedef logic [31:0] inst_t;     // raw instruction word

    typedef logic [4:0] reg_idx_t;   // x0..x31

    // control fields carried from decode to execute
    typedef logic [3:0] alu_op_t;
    typedef logic [1:0] opa_sel_t;
    typedef logic [1:0] opb_sel_t;

    typedef logic [2:0] br_cond_t;   // branch funct3

endpackage

`default_nettype wire

// ==== logic/rv_pipe_top.sv ====
`default_nettype none

module rv_pipe_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  rv_pipe_pkg::inst_t    in_inst,
    input  rv_pipe_pkg::xlen_t    in_pc,
    output logic                  in_allowin,
    output logic                  retire_valid,
    output rv_pipe_pkg::xlen_t    retire_pc,
    output rv_pipe_pkg::reg_idx_t retire_rd,
    output logic                  retire_wen,
    output rv_pipe_pkg::xlen_t    retire_value,
    output logic                  retire_br_taken,
    output rv_pipe_pkg::xlen_t    retire_br_target,
    input  logic                  retire_ready
);
    logic                  ds_to_es_valid, es_to_rs_valid;
    logic                  es_allowin, rs_allowin;
    rv_pipe_pkg::xlen_t    ds_pc, ds_src1, ds_src2, ds_imm;
    rv_pipe_pkg::alu_op_t  ds_alu_op;
    rv_pipe_pkg::opa_sel_t ds_opa_sel;
    rv_pipe_pkg::opb_sel_t ds_opb_sel;
    rv_pipe_pkg::reg_idx_t ds_rd, es_rd, es_busy_rd;
    logic                  ds_reg_wen, ds_is_branch, es_reg_wen, es_busy_wen;
    rv_pipe_pkg::br_cond_t ds_br_cond;
    rv_pipe_pkg::xlen_t    es_pc, es_result, es_br_target;
    logic                  es_br_taken;
    rv_pipe_pkg::reg_idx_t rf_raddr1, rf_raddr2, rf_waddr;
    rv_pipe_pkg::xlen_t    rf_rdata1, rf_rdata2, rf_wdata;
    logic                  rf_we;

    decode_stage u_decode (
        .rs_busy_rd  (retire_rd),  // retiring instruction's pending write
        .rs_busy_wen (retire_wen),
        .*
    );

    execute_stage u_execute (.*);

    result_stage u_result (.*);

    register_file u_register_file (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== verification/rv_pipe_clock.sv ====
`default_nettype none

module rv_pipe_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== verification/rv_pipe_sva.sv ====
`default_nettype none

module rv_pipe_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  retire_valid,
    input logic                  retire_ready,
    input rv_pipe_pkg::xlen_t    retire_pc,
    input rv_pipe_pkg::reg_idx_t retire_rd,
    input logic                  retire_wen,
    input rv_pipe_pkg::xlen_t    retire_value,
    input logic                  retire_br_taken,
    input rv_pipe_pkg::xlen_t    retire_br_target
);
    int unsigned fail_count = 0; // number of failed assertions

    assert property (@(posedge clk) rst |=> !retire_valid) // empty right after reset
        else begin
            fail_count++;
            $error("retire_valid high in the cycle after reset");
        end

    // a stalled retire record must hold still
    assert property (@(posedge clk) disable iff (rst)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_rd) && $stable(retire_wen) && $stable(retire_value)
            && $stable(retire_br_taken) && $stable(retire_br_target))
        else begin
            fail_count++;
            $error("retire fields changed while retire_ready was low");
        end

    assert property (@(posedge clk) disable iff (rst) retire_wen |-> retire_rd != 5'd0)
        else begin
            fail_count++;
            $error("retire_wen set for a write to x0");
        end

endmodule

bind rv_pipe_top rv_pipe_sva sva0 (.*);

`default_nettype wire

// ==== verification/rv_pipe_tb.sv ====
`default_nettype none

`include "rv_pipe_cfg.svh"

module rv_pipe_tb;
    localparam int NUM_INST = 400;
    localparam int TIMEOUT_CYCLES = NUM_INST * 20 + 100;
    localparam rv_pipe_pkg::xlen_t PC_BASE = 64'h0000_0000_8000_0000;

    typedef struct packed {
        rv_pipe_pkg::xlen_t    pc;
        rv_pipe_pkg::reg_idx_t rd;
        logic                  wen;
        rv_pipe_pkg::xlen_t    value;
        logic                  is_br;
        logic                  taken;
        rv_pipe_pkg::xlen_t    target;
    } expect_t;

    logic clk, rst, in_valid, in_allowin, retire_ready;
    rv_pipe_pkg::inst_t    in_inst, cur_inst;
    rv_pipe_pkg::xlen_t    in_pc, cur_pc;
    logic                  retire_valid, retire_wen, retire_br_taken;
    rv_pipe_pkg::xlen_t    retire_pc, retire_value, retire_br_target;
    rv_pipe_pkg::reg_idx_t retire_rd;
    logic [31:0]           lfsr;
    rv_pipe_pkg::xlen_t    mregs [32]; // architectural state of the model
    expect_t               exp_q [$];
    int                    sent, retired, cycles;
    logic                  accepted;

    rv_pipe_clock #(.PERIOD(100)) clk_gen (.clk(clk));

    rv_pipe_top dut0 (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic rv_pipe_pkg::inst_t make_instruction();
        logic [2:0]  kind, f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic [19:0] upper;
        logic        alt;
        kind = 3'(take_bits(3));
        f3   = 3'(take_bits(3));
        rd   = {2'b00, 3'(take_bits(3))}; // x0..x7 keeps hazards frequent
        rs1  = {2'b00, 3'(take_bits(3))};
        rs2  = {2'b00, 3'(take_bits(3))};
        alt  = take_bits(1) != 0;
        case (kind)
            3'd0, 3'd1: return {((f3 == 3'b000 || f3 == 3'b101) && alt) ? 7'b0100000 : 7'b0,
                                rs2, rs1, f3, rd, `OPC_OP};
            3'd2, 3'd3: begin
                imm = 12'(take_bits(12));
                if (f3 == 3'b001) begin
                    imm[11:6] = 6'b000000;
                end else if (f3 == 3'b101) begin
                    imm[11:6] = alt ? 6'b010000 : 6'b000000; // srai or srli
                end
                return {imm, rs1, f3, rd, `OPC_OP_IMM};
            end
            3'd4: begin
                upper = 20'(take_bits(20));
                return {upper, rd, alt ? `OPC_LUI : `OPC_AUIPC};
            end
            3'd5, 3'd6: begin
                if (f3[2:1] == 2'b01) begin
                    f3[1] = 1'b0; // funct3 010 and 011 are not branches
                end
                imm = 12'(take_bits(12));
                return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_BRANCH};
            end
            default: return {25'(take_bits(25)), 7'b0000011}; // load, retires as no-write
        endcase
    endfunction

    function automatic rv_pipe_pkg::xlen_t int_op(input logic [2:0] f3, input logic alt,
                                                  input rv_pipe_pkg::xlen_t x,
                                                  input rv_pipe_pkg::xlen_t y);
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[5:0];
            3'b010:  return {63'b0, $signed(x) < $signed(y)};
            3'b011:  return {63'b0, x < y};
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt) begin
                    return $signed(x) >>> y[5:0];
                end
                return x >> y[5:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic expect_t execute_model(input rv_pipe_pkg::inst_t inst,
                                              input rv_pipe_pkg::xlen_t pc);
        expect_t            e;
        rv_pipe_pkg::xlen_t a, b, imm_i, imm_u, imm_b;
        logic [2:0]         f3;
        logic               writes;
        f3     = inst[14:12];
        a      = mregs[inst[19:15]];
        b      = mregs[inst[24:20]];
        imm_i  = {{52{inst[31]}}, inst[31:20]};
        imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
        imm_b  = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        e      = '0;
        e.pc   = pc;
        e.rd   = inst[11:7];
        writes = 1'b1;
        case (inst[6:0])
            `OPC_OP:     e.value = int_op(f3, inst[30], a, b);
            `OPC_OP_IMM: e.value = int_op(f3, inst[30] && f3 == 3'b101, a, imm_i);
            `OPC_LUI:    e.value = imm_u;
            `OPC_AUIPC:  e.value = pc + imm_u;
            `OPC_BRANCH: begin
                writes   = 1'b0;
                e.is_br  = 1'b1;
                e.target = pc + imm_b;
                case (f3)
                    3'b000:  e.taken = a == b;
                    3'b001:  e.taken = a != b;
                    3'b100:  e.taken = $signed(a) < $signed(b);
                    3'b101:  e.taken = $signed(a) >= $signed(b);
                    3'b110:  e.taken = a < b;
                    default: e.taken = a >= b;
                endcase
            end
            default: writes = 1'b0;
        endcase
        e.wen = writes && e.rd != 5'd0; // x0 is never written
        if (e.wen) begin
            mregs[e.rd] = e.value;
        end
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string field, input rv_pipe_pkg::xlen_t actual,
                               input rv_pipe_pkg::xlen_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at time %0t: %s is %h, expected %h",
                                $time, field, actual, expected));
        end
    endtask

    // handshakes are sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin : monitor
        expect_t e;
        if (!rst) begin
            if (in_valid && in_allowin) begin
                exp_q.push_back(execute_model(in_inst, in_pc));
                sent++;
                accepted = 1'b1;
            end
            if (retire_valid && retire_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("an instruction retired that was never sent");
                end else begin
                    e = exp_q.pop_front();
                    check_value("retire_pc", retire_pc, e.pc);
                    check_value("retire_wen", 64'(retire_wen), 64'(e.wen));
                    check_value("retire_br_taken", 64'(retire_br_taken), 64'(e.taken));
                    if (e.wen) begin
                        check_value("retire_rd", 64'(retire_rd), 64'(e.rd));
                        check_value("retire_value", retire_value, e.value);
                    end
                    if (e.is_br) begin
                        check_value("retire_br_target", retire_br_target, e.target);
                    end
                    retired++;
                end
            end
        end
    end

    initial begin
        lfsr = 32'h69df_e331;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        in_pc        = '0;
        retire_ready = 1'b0;
        sent         = 0;
        retired      = 0;
        cycles       = 0;
        accepted     = 1'b0;
        cur_pc       = PC_BASE;
        cur_inst     = make_instruction();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (retired < NUM_INST) begin
            @(negedge clk);
            cycles++;
            if (dut0.sva0.fail_count != 0) begin
                abort_run("an assertion on the retire port failed");
            end
            if (cycles > TIMEOUT_CYCLES) begin
                abort_run("timeout: not all instructions retired");
            end
            if (accepted) begin
                accepted = 1'b0;
                cur_pc   = cur_pc + 64'd4;
                cur_inst = make_instruction();
            end
            in_valid     = (take_bits(1) != 0) && (sent < NUM_INST);
            in_inst      = cur_inst;
            in_pc        = cur_pc;
            retire_ready = take_bits(1) != 0;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
logic/rv_pipe_pkg.sv
logic/alu.sv
logic/branch_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_pipe_top.sv
verification/rv_pipe_clock.sv
verification/rv_pipe_sva.sv
verification/rv_pipe_tb.sv
